//--- compile.f
+incdir+include
+incdir+tb
verilog/axi_pkg.sv
verilog/soc_map_pkg.sv
verilog/axi_sram.sv
verilog/clint_timer.sv
verilog/axi_xbar.sv
verilog/axi_soc_top.sv
tb/tb_axi_soc.sv

//--- tb/axi_patterns.hex
// op addr len seed strb resp, one operation per line, all hex
// op 1 write, 2 read, 3 mtime read, 4 R back-pressure (seed 1 on), 0 end
1 80000000 0 a5a50001 f 0
2 80000000 0 00000000 0 0
1 80000010 3 11220000 f 0
2 80000010 3 00000000 0 0
1 80000040 0 cafebabe f 0
1 80000040 0 12345678 5 0
2 80000040 0 00000000 0 0
3 0200bff8 0 00000000 0 0
3 0200bff8 0 00000000 0 0
1 02000000 0 dead0000 f 2
2 10000000 1 00000000 0 3
4 00000000 0 00000001 0 0
1 80000080 3 33440000 f 0
2 80000080 3 00000000 0 0
1 800000c0 0 ffffffff f 0
1 800000c0 0 01020304 a 0
2 800000c0 0 00000000 0 0
2 80000010 3 00000000 0 0
3 0200bff8 0 00000000 0 0
3 0200bff8 0 00000000 0 0
1 02000008 1 beef0000 f 2
2 10000000 1 00000000 0 3
0 00000000 0 00000000 0 0

//--- tb/tb_axi_tasks.svh
//--------------------------------------------------
// AXI master tasks and value check for the testbench
//--------------------------------------------------
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp) begin
		$display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
		abort_run("value mismatch on the master port");
	end
endtask

// AW first, then all W beats, then wait for B
task automatic burst_write(input logic [`ADDR_LEN-1:0] addr, input logic [7:0] len,
	input logic [31:0] seed, input logic [3:0] strb, input logic [3:0] id,
	input logic [1:0] exp_resp);
	int beat;
	aw_addr = addr;
	aw_len = len;
	aw_id = id;
	aw_valid = 1'b1;
	do @(negedge clock); while (!aw_ready);
	@(posedge clock);
	#2;
	aw_valid = 1'b0;
	for (beat = 0; beat <= len; beat++) begin
		w_data = seed + beat;	// seed plus beat index
		w_strb = strb;
		w_last = (beat == len);
		w_valid = 1'b1;
		do @(negedge clock); while (!w_ready);
		@(posedge clock);
		#2;
	end
	w_valid = 1'b0;
	w_last = 1'b0;
	do @(negedge clock); while (!b_valid);
	check_value("b_resp", b_resp, exp_resp);
	check_value("b_id", b_id, id);
	@(posedge clock);
	#2;
endtask

// handles AR and R per cycle since DECERR may answer in the AR cycle
task automatic burst_read(input logic [`ADDR_LEN-1:0] addr, input logic [7:0] len,
	input logic [3:0] id, input logic [1:0] exp_resp);
	int beat;
	logic ar_done;
	beat = 0;
	rdata_q.delete();
	ar_addr = addr;
	ar_len = len;
	ar_id = id;
	ar_valid = 1'b1;
	r_ready = pick_r_ready();
	while (beat <= len) begin
		@(negedge clock);
		ar_done = ar_valid && ar_ready;
		if (r_valid && r_ready) begin
			check_value("r_resp", r_resp, exp_resp);
			check_value("r_last", r_last, beat == len);
			check_value("r_id", r_id, id);
			rdata_q.push_back(r_data);
			beat++;
		end
		@(posedge clock);
		#2;
		if (ar_done)
			ar_valid = 1'b0;
		r_ready = pick_r_ready();
	end
	ar_valid = 1'b0;
	r_ready = 1'b0;
endtask

`endif

//--- tb/tb_axi_soc.sv
//--------------------------------------------------
// testbench for the AXI subsystem, pattern driven
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

module tb_axi_soc;
	import axi_pkg::*;

	localparam int MAX_OPS = 32;
	localparam int COLS = 6;	// op addr len seed strb resp
	localparam int CYCLES_PER_OP = 200;

	logic clock, reset_i;
	logic [`ADDR_LEN-1:0] ar_addr, aw_addr;
	logic ar_valid, ar_ready, aw_valid, aw_ready;
	axi_id_t ar_id, aw_id, r_id, b_id;
	axi_len_t ar_len, aw_len;
	axi_size_t ar_size, aw_size;
	axi_burst_t ar_burst, aw_burst;
	logic [`DATA_LEN-1:0] r_data, w_data;
	axi_resp_t r_resp, b_resp;
	logic r_valid, r_ready, r_last;
	logic [`DATA_LEN/8-1:0] w_strb;
	logic w_valid, w_ready, w_last;
	logic b_valid, b_ready;

	logic [31:0] patterns [0:MAX_OPS*COLS-1];
	logic [31:0] model [0:`SRAM_WORDS-1];	// expected SRAM contents
	logic [31:0] rdata_q [$];
	integer rand_seed;
	logic backpressure;
	int n_ops;
	logic have_mtime;
	logic [31:0] last_mtime;

	`include "tb_axi_tasks.svh"

	axi_soc_top DUT (
		.clock(clock), .reset_i(reset_i),
		.axi_ctl_addr_r_addr_i(ar_addr), .axi_ctl_addr_r_valid_i(ar_valid),
		.axi_ctl_addr_r_ready_o(ar_ready), .axi_ctl_addr_r_id_i(ar_id),
		.axi_ctl_addr_r_len_i(ar_len), .axi_ctl_addr_r_size_i(ar_size),
		.axi_ctl_addr_r_burst_i(ar_burst),
		.axi_ctl_r_data_o(r_data), .axi_ctl_r_resp_o(r_resp), .axi_ctl_r_valid_o(r_valid),
		.axi_ctl_r_ready_i(r_ready), .axi_ctl_r_last_o(r_last), .axi_ctl_r_id_o(r_id),
		.axi_ctl_addr_w_addr_i(aw_addr), .axi_ctl_addr_w_valid_i(aw_valid),
		.axi_ctl_addr_w_ready_o(aw_ready), .axi_ctl_addr_w_id_i(aw_id),
		.axi_ctl_addr_w_len_i(aw_len), .axi_ctl_addr_w_size_i(aw_size),
		.axi_ctl_addr_w_burst_i(aw_burst),
		.axi_ctl_w_data_i(w_data), .axi_ctl_w_strb_i(w_strb), .axi_ctl_w_valid_i(w_valid),
		.axi_ctl_w_ready_o(w_ready), .axi_ctl_w_last_i(w_last),
		.axi_ctl_bkwd_resp_o(b_resp), .axi_ctl_bkwd_valid_o(b_valid),
		.axi_ctl_bkwd_ready_i(b_ready), .axi_ctl_bkwd_id_o(b_id)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic logic pick_r_ready();
		logic [31:0] r;
		if (!backpressure)
			return 1'b1;
		r = $random(rand_seed);
		return r[0];
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [7:0] len,
		input logic [31:0] seed, input logic [3:0] strb);
		int b;
		int k;
		int idx;
		logic [31:0] word;
		for (b = 0; b <= len; b++) begin
			idx = (addr - `SRAM_BASE) / 4 + b;
			word = seed + b;
			for (k = 0; k < 4; k++) begin
				if (strb[k])
					model[idx][k*8 +: 8] = word[k*8 +: 8];
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		wait (n_ops > 0);
		repeat (n_ops * CYCLES_PER_OP) @(posedge clock);
		abort_run("timeout: the pattern list did not finish in time");
	end

	initial begin
		int i;
		int b;
		logic [31:0] op, addr, seed, exp_data;
		logic [7:0] len;
		logic [3:0] strb;
		logic [1:0] resp;
		logic [3:0] id;
		reset_i = 1'b1;
		ar_addr = '0;
		ar_valid = 1'b0;
		ar_id = '0;
		ar_len = '0;
		ar_size = SIZE_4B;
		ar_burst = BURST_INCR;
		r_ready = 1'b0;
		aw_addr = '0;
		aw_valid = 1'b0;
		aw_id = '0;
		aw_len = '0;
		aw_size = SIZE_4B;
		aw_burst = BURST_INCR;
		w_data = '0;
		w_strb = '0;
		w_valid = 1'b0;
		w_last = 1'b0;
		b_ready = 1'b1;	// B never stalled
		rand_seed = 32'h18f3_dba0;
		backpressure = 1'b0;
		have_mtime = 1'b0;
		last_mtime = '0;
		n_ops = 0;
		$readmemh("tb/axi_patterns.hex", patterns);
		while (n_ops < MAX_OPS && patterns[n_ops*COLS] inside {32'd1, 32'd2, 32'd3, 32'd4})
			n_ops++;
		if (n_ops == 0)
			abort_run("no usable lines in the pattern file");
		repeat (4) @(posedge clock);
		#2;
		reset_i = 1'b0;
		for (i = 0; i < n_ops; i++) begin
			op = patterns[i*COLS];
			addr = patterns[i*COLS+1];
			len = patterns[i*COLS+2][7:0];
			seed = patterns[i*COLS+3];
			strb = patterns[i*COLS+4][3:0];
			resp = patterns[i*COLS+5][1:0];
			id = 4'(i);
			case (op)
				32'd1: begin
					burst_write(addr, len, seed, strb, id, resp);
					if (resp == RESP_OKAY)
						model_write(addr, len, seed, strb);
				end
				32'd2: begin
					burst_read(addr, len, id, resp);
					for (b = 0; b <= len; b++) begin
						exp_data = (resp == RESP_OKAY) ?
							model[(addr - `SRAM_BASE) / 4 + b] : '0;
						check_value("r_data", rdata_q[b], exp_data);
					end
				end
				32'd3: begin
					burst_read(addr, 8'd0, id, resp);
					if (have_mtime)
						check_value("mtime_rises", rdata_q[0] > last_mtime, 32'd1);
					last_mtime = rdata_q[0];
					have_mtime = 1'b1;
				end
				default: backpressure = seed[0];	// R ready on or random
			endcase
		end
		repeat (2) @(posedge clock);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/axi_soc_top.sv
//--------------------------------------------------
// memory subsystem: crossbar, SRAM and CLINT
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

module axi_soc_top (
	input wire logic clock,
	input wire logic reset_i,

	input wire logic [`ADDR_LEN-1:0] axi_ctl_addr_r_addr_i,
	input wire logic axi_ctl_addr_r_valid_i,
	output logic axi_ctl_addr_r_ready_o,
	input wire axi_pkg::axi_id_t axi_ctl_addr_r_id_i,
	input wire axi_pkg::axi_len_t axi_ctl_addr_r_len_i,
	input wire axi_pkg::axi_size_t axi_ctl_addr_r_size_i,
	input wire axi_pkg::axi_burst_t axi_ctl_addr_r_burst_i,
	output logic [`DATA_LEN-1:0] axi_ctl_r_data_o,
	output axi_pkg::axi_resp_t axi_ctl_r_resp_o,
	output logic axi_ctl_r_valid_o,
	input wire logic axi_ctl_r_ready_i,
	output logic axi_ctl_r_last_o,
	output axi_pkg::axi_id_t axi_ctl_r_id_o,
	input wire logic [`ADDR_LEN-1:0] axi_ctl_addr_w_addr_i,
	input wire logic axi_ctl_addr_w_valid_i,
	output logic axi_ctl_addr_w_ready_o,
	input wire axi_pkg::axi_id_t axi_ctl_addr_w_id_i,
	input wire axi_pkg::axi_len_t axi_ctl_addr_w_len_i,
	input wire axi_pkg::axi_size_t axi_ctl_addr_w_size_i,
	input wire axi_pkg::axi_burst_t axi_ctl_addr_w_burst_i,
	input wire logic [`DATA_LEN-1:0] axi_ctl_w_data_i,
	input wire logic [`DATA_LEN/8-1:0] axi_ctl_w_strb_i,
	input wire logic axi_ctl_w_valid_i,
	output logic axi_ctl_w_ready_o,
	input wire logic axi_ctl_w_last_i,
	output axi_pkg::axi_resp_t axi_ctl_bkwd_resp_o,
	output logic axi_ctl_bkwd_valid_o,
	input wire logic axi_ctl_bkwd_ready_i,
	output axi_pkg::axi_id_t axi_ctl_bkwd_id_o
);
	import axi_pkg::*;

	logic [`ADDR_LEN-1:0] sram_ar_addr, sram_aw_addr, clint_addr;
	logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready, sram_r_last;
	logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready, sram_w_last;
	logic sram_b_valid, sram_b_ready;
	axi_id_t sram_ar_id, sram_r_id, sram_aw_id, sram_b_id;
	axi_len_t sram_ar_len, sram_aw_len;
	axi_size_t sram_ar_size, sram_aw_size;
	axi_burst_t sram_ar_burst, sram_aw_burst;
	axi_resp_t sram_r_resp, sram_b_resp, clint_resp;
	logic [`DATA_LEN-1:0] sram_r_data, sram_w_data, clint_data;
	logic [`DATA_LEN/8-1:0] sram_w_strb;
	logic clint_req_valid, clint_req_ready, clint_rsp_valid, clint_rsp_ready;

	axi_xbar u_xbar (
		.*,	// clock, reset and the master port
		.axi_addr_r_addr_o(sram_ar_addr), .axi_addr_r_valid_o(sram_ar_valid),
		.axi_addr_r_ready_i(sram_ar_ready), .axi_addr_r_id_o(sram_ar_id),
		.axi_addr_r_len_o(sram_ar_len), .axi_addr_r_size_o(sram_ar_size),
		.axi_addr_r_burst_o(sram_ar_burst),
		.axi_r_data_i(sram_r_data), .axi_r_resp_i(sram_r_resp), .axi_r_valid_i(sram_r_valid),
		.axi_r_ready_o(sram_r_ready), .axi_r_last_i(sram_r_last), .axi_r_id_i(sram_r_id),
		.axi_addr_w_addr_o(sram_aw_addr), .axi_addr_w_valid_o(sram_aw_valid),
		.axi_addr_w_ready_i(sram_aw_ready), .axi_addr_w_id_o(sram_aw_id),
		.axi_addr_w_len_o(sram_aw_len), .axi_addr_w_size_o(sram_aw_size),
		.axi_addr_w_burst_o(sram_aw_burst),
		.axi_w_data_o(sram_w_data), .axi_w_strb_o(sram_w_strb), .axi_w_valid_o(sram_w_valid),
		.axi_w_ready_i(sram_w_ready), .axi_w_last_o(sram_w_last),
		.axi_bkwd_resp_i(sram_b_resp), .axi_bkwd_valid_i(sram_b_valid),
		.axi_bkwd_ready_o(sram_b_ready), .axi_bkwd_id_i(sram_b_id),
		.clint_req_addr_o(clint_addr), .clint_req_valid_o(clint_req_valid),
		.clint_req_ready_i(clint_req_ready), .clint_rsp_data_i(clint_data),
		.clint_rsp_resp_i(clint_resp), .clint_rsp_valid_i(clint_rsp_valid),
		.clint_rsp_ready_o(clint_rsp_ready)
	);

	axi_sram u_sram (
		.clock(clock), .reset_i(reset_i),
		.axi_addr_r_addr_i(sram_ar_addr), .axi_addr_r_valid_i(sram_ar_valid),
		.axi_addr_r_ready_o(sram_ar_ready), .axi_addr_r_id_i(sram_ar_id),
		.axi_addr_r_len_i(sram_ar_len), .axi_addr_r_size_i(sram_ar_size),
		.axi_addr_r_burst_i(sram_ar_burst),
		.axi_r_data_o(sram_r_data), .axi_r_resp_o(sram_r_resp), .axi_r_valid_o(sram_r_valid),
		.axi_r_ready_i(sram_r_ready), .axi_r_last_o(sram_r_last), .axi_r_id_o(sram_r_id),
		.axi_addr_w_addr_i(sram_aw_addr), .axi_addr_w_valid_i(sram_aw_valid),
		.axi_addr_w_ready_o(sram_aw_ready), .axi_addr_w_id_i(sram_aw_id),
		.axi_addr_w_len_i(sram_aw_len), .axi_addr_w_size_i(sram_aw_size),
		.axi_addr_w_burst_i(sram_aw_burst),
		.axi_w_data_i(sram_w_data), .axi_w_strb_i(sram_w_strb), .axi_w_valid_i(sram_w_valid),
		.axi_w_ready_o(sram_w_ready), .axi_w_last_i(sram_w_last),
		.axi_bkwd_resp_o(sram_b_resp), .axi_bkwd_valid_o(sram_b_valid),
		.axi_bkwd_ready_i(sram_b_ready), .axi_bkwd_id_o(sram_b_id)
	);

	clint_timer u_clint (
		.clock(clock), .reset_i(reset_i),
		.req_addr_i(clint_addr), .req_valid_i(clint_req_valid), .req_ready_o(clint_req_ready),
		.rsp_data_o(clint_data), .rsp_resp_o(clint_resp),
		.rsp_valid_o(clint_rsp_valid), .rsp_ready_i(clint_rsp_ready)
	);

endmodule

`default_nettype wire

//--- verilog/axi_xbar.sv
//--------------------------------------------------
// AXI crossbar to SRAM and CLINT with error replies
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

module axi_xbar (
	input wire logic clock,
	input wire logic reset_i,

	input wire logic [`ADDR_LEN-1:0] axi_ctl_addr_r_addr_i,
	input wire logic axi_ctl_addr_r_valid_i,
	output logic axi_ctl_addr_r_ready_o,
	input wire axi_pkg::axi_id_t axi_ctl_addr_r_id_i,
	input wire axi_pkg::axi_len_t axi_ctl_addr_r_len_i,
	input wire axi_pkg::axi_size_t axi_ctl_addr_r_size_i,
	input wire axi_pkg::axi_burst_t axi_ctl_addr_r_burst_i,
	output logic [`DATA_LEN-1:0] axi_ctl_r_data_o,
	output axi_pkg::axi_resp_t axi_ctl_r_resp_o,
	output logic axi_ctl_r_valid_o,
	input wire logic axi_ctl_r_ready_i,
	output logic axi_ctl_r_last_o,
	output axi_pkg::axi_id_t axi_ctl_r_id_o,
	input wire logic [`ADDR_LEN-1:0] axi_ctl_addr_w_addr_i,
	input wire logic axi_ctl_addr_w_valid_i,
	output logic axi_ctl_addr_w_ready_o,
	input wire axi_pkg::axi_id_t axi_ctl_addr_w_id_i,
	input wire axi_pkg::axi_len_t axi_ctl_addr_w_len_i,
	input wire axi_pkg::axi_size_t axi_ctl_addr_w_size_i,
	input wire axi_pkg::axi_burst_t axi_ctl_addr_w_burst_i,
	input wire logic [`DATA_LEN-1:0] axi_ctl_w_data_i,
	input wire logic [`DATA_LEN/8-1:0] axi_ctl_w_strb_i,
	input wire logic axi_ctl_w_valid_i,
	output logic axi_ctl_w_ready_o,
	input wire logic axi_ctl_w_last_i,
	output axi_pkg::axi_resp_t axi_ctl_bkwd_resp_o,
	output logic axi_ctl_bkwd_valid_o,
	input wire logic axi_ctl_bkwd_ready_i,
	output axi_pkg::axi_id_t axi_ctl_bkwd_id_o,

	output logic [`ADDR_LEN-1:0] axi_addr_r_addr_o,
	output logic axi_addr_r_valid_o,
	input wire logic axi_addr_r_ready_i,
	output axi_pkg::axi_id_t axi_addr_r_id_o,
	output axi_pkg::axi_len_t axi_addr_r_len_o,
	output axi_pkg::axi_size_t axi_addr_r_size_o,
	output axi_pkg::axi_burst_t axi_addr_r_burst_o,
	input wire logic [`DATA_LEN-1:0] axi_r_data_i,
	input wire axi_pkg::axi_resp_t axi_r_resp_i,
	input wire logic axi_r_valid_i,
	output logic axi_r_ready_o,
	input wire logic axi_r_last_i,
	input wire axi_pkg::axi_id_t axi_r_id_i,
	output logic [`ADDR_LEN-1:0] axi_addr_w_addr_o,
	output logic axi_addr_w_valid_o,
	input wire logic axi_addr_w_ready_i,
	output axi_pkg::axi_id_t axi_addr_w_id_o,
	output axi_pkg::axi_len_t axi_addr_w_len_o,
	output axi_pkg::axi_size_t axi_addr_w_size_o,
	output axi_pkg::axi_burst_t axi_addr_w_burst_o,
	output logic [`DATA_LEN-1:0] axi_w_data_o,
	output logic [`DATA_LEN/8-1:0] axi_w_strb_o,
	output logic axi_w_valid_o,
	input wire logic axi_w_ready_i,
	output logic axi_w_last_o,
	input wire axi_pkg::axi_resp_t axi_bkwd_resp_i,
	input wire logic axi_bkwd_valid_i,
	output logic axi_bkwd_ready_o,
	input wire axi_pkg::axi_id_t axi_bkwd_id_i,

	output logic [`ADDR_LEN-1:0] clint_req_addr_o,
	output logic clint_req_valid_o,
	input wire logic clint_req_ready_i,
	input wire logic [`DATA_LEN-1:0] clint_rsp_data_i,
	input wire axi_pkg::axi_resp_t clint_rsp_resp_i,
	input wire logic clint_rsp_valid_i,
	output logic clint_rsp_ready_o
);
	import axi_pkg::*;
	import soc_map_pkg::*;

	xbar_dev_t ar_dev, aw_dev;
	xbar_dev_t rd_dev, wr_dev;	// latched targets
	logic rd_busy, wr_busy;
	logic err_b_valid;	// B from the crossbar itself
	axi_id_t rd_id, wr_id;
	axi_len_t rd_cnt;	// DECERR beats left
	logic ar_hs, r_hs, w_hs, b_hs;

	assign ar_dev = addr_to_dev(axi_ctl_addr_r_addr_i);
	assign aw_dev = addr_to_dev(axi_ctl_addr_w_addr_i);
	assign ar_hs = axi_ctl_addr_r_valid_i && axi_ctl_addr_r_ready_o;
	assign r_hs = axi_ctl_r_valid_o && axi_ctl_r_ready_i;
	assign w_hs = axi_ctl_w_valid_i && axi_ctl_w_ready_o;
	assign b_hs = axi_ctl_bkwd_valid_o && axi_ctl_bkwd_ready_i;

	assign axi_addr_r_addr_o = axi_ctl_addr_r_addr_i;
	assign axi_addr_r_id_o = axi_ctl_addr_r_id_i;
	assign axi_addr_r_len_o = axi_ctl_addr_r_len_i;
	assign axi_addr_r_size_o = axi_ctl_addr_r_size_i;
	assign axi_addr_r_burst_o = axi_ctl_addr_r_burst_i;
	assign axi_addr_r_valid_o = axi_ctl_addr_r_valid_i && !rd_busy && ar_dev == DEV_SRAM;
	assign clint_req_addr_o = axi_ctl_addr_r_addr_i;
	assign clint_req_valid_o = axi_ctl_addr_r_valid_i && !rd_busy && ar_dev == DEV_CLINT;
	assign axi_ctl_addr_r_ready_o = !rd_busy && (ar_dev == DEV_SRAM ? axi_addr_r_ready_i :
		ar_dev == DEV_CLINT ? clint_req_ready_i : 1'b1);

	always_comb begin
		axi_ctl_r_valid_o = 1'b0;
		axi_ctl_r_data_o = '0;
		axi_ctl_r_resp_o = RESP_DECERR;
		axi_ctl_r_last_o = (rd_cnt == '0);
		axi_ctl_r_id_o = rd_id;
		axi_r_ready_o = 1'b0;
		clint_rsp_ready_o = 1'b0;
		if (!rd_busy) begin
			// unmapped read answers in the AR cycle
			axi_ctl_r_valid_o = axi_ctl_addr_r_valid_i && ar_dev == DEV_NONE;
			axi_ctl_r_last_o = (axi_ctl_addr_r_len_i == '0);
			axi_ctl_r_id_o = axi_ctl_addr_r_id_i;
		end else if (rd_dev == DEV_SRAM) begin
			axi_ctl_r_valid_o = axi_r_valid_i;
			axi_ctl_r_data_o = axi_r_data_i;
			axi_ctl_r_resp_o = axi_r_resp_i;
			axi_ctl_r_last_o = axi_r_last_i;
			axi_ctl_r_id_o = axi_r_id_i;
			axi_r_ready_o = axi_ctl_r_ready_i;
		end else if (rd_dev == DEV_CLINT) begin
			axi_ctl_r_valid_o = clint_rsp_valid_i;
			axi_ctl_r_data_o = clint_rsp_data_i;
			axi_ctl_r_resp_o = clint_rsp_resp_i;
			axi_ctl_r_last_o = 1'b1;	// always one beat
			clint_rsp_ready_o = axi_ctl_r_ready_i;
		end else begin
			axi_ctl_r_valid_o = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			rd_busy <= 1'b0;
			rd_dev <= DEV_NONE;
		end else if (!rd_busy) begin
			if (ar_hs) begin
				rd_dev <= ar_dev;
				rd_id <= axi_ctl_addr_r_id_i;
				rd_cnt <= axi_ctl_addr_r_len_i;
				rd_busy <= !(r_hs && axi_ctl_r_last_o);
				if (r_hs)
					rd_cnt <= axi_ctl_addr_r_len_i - 1'b1;	// first beat already gone
			end
		end else if (r_hs) begin
			rd_busy <= !axi_ctl_r_last_o;
			rd_cnt <= rd_cnt - 1'b1;
		end
	end

	assign axi_addr_w_addr_o = axi_ctl_addr_w_addr_i;
	assign axi_addr_w_id_o = axi_ctl_addr_w_id_i;
	assign axi_addr_w_len_o = axi_ctl_addr_w_len_i;
	assign axi_addr_w_size_o = axi_ctl_addr_w_size_i;
	assign axi_addr_w_burst_o = axi_ctl_addr_w_burst_i;
	assign axi_addr_w_valid_o = axi_ctl_addr_w_valid_i && !wr_busy && aw_dev == DEV_SRAM;
	assign axi_ctl_addr_w_ready_o = !wr_busy && (aw_dev != DEV_SRAM || axi_addr_w_ready_i);

	assign axi_w_data_o = axi_ctl_w_data_i;
	assign axi_w_strb_o = axi_ctl_w_strb_i;
	assign axi_w_last_o = axi_ctl_w_last_i;
	assign axi_w_valid_o = axi_ctl_w_valid_i && wr_busy && wr_dev == DEV_SRAM;
	assign axi_ctl_w_ready_o = wr_busy && (wr_dev == DEV_SRAM ? axi_w_ready_i : !err_b_valid);

	assign axi_bkwd_ready_o = axi_ctl_bkwd_ready_i && wr_busy && wr_dev == DEV_SRAM;
	assign axi_ctl_bkwd_valid_o = wr_busy && (wr_dev == DEV_SRAM ? axi_bkwd_valid_i : err_b_valid);
	assign axi_ctl_bkwd_id_o = (wr_dev == DEV_SRAM) ? axi_bkwd_id_i : wr_id;
	assign axi_ctl_bkwd_resp_o = (wr_dev == DEV_SRAM) ? axi_bkwd_resp_i :
		(wr_dev == DEV_CLINT) ? RESP_SLVERR : RESP_DECERR;	// mtime is read-only

	always_ff @(posedge clock) begin
		if (reset_i) begin
			wr_busy <= 1'b0;
			wr_dev <= DEV_NONE;
			err_b_valid <= 1'b0;
		end else begin
			if (axi_ctl_addr_w_valid_i && axi_ctl_addr_w_ready_o) begin
				wr_busy <= 1'b1;
				wr_dev <= aw_dev;
				wr_id <= axi_ctl_addr_w_id_i;
			end
			if (w_hs && wr_dev != DEV_SRAM && axi_ctl_w_last_i)
				err_b_valid <= 1'b1;	// swallowed burst done
			if (b_hs) begin
				wr_busy <= 1'b0;
				err_b_valid <= 1'b0;
			end
		end
	end

	// AR stays closed until the read burst has drained
	assert property (@(posedge clock) disable iff (reset_i)
		r_hs && !axi_ctl_r_last_o |=> !axi_ctl_addr_r_ready_o);

	// only the selected device may offer a response
	assert property (@(posedge clock) disable iff (reset_i)
		axi_r_valid_i |-> rd_busy && rd_dev == DEV_SRAM);
	assert property (@(posedge clock) disable iff (reset_i)
		clint_rsp_valid_i |-> rd_busy && rd_dev == DEV_CLINT);
	assert property (@(posedge clock) disable iff (reset_i)
		axi_bkwd_valid_i |-> wr_busy && wr_dev == DEV_SRAM);

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
//--------------------------------------------------
// free-running mtime with a read-only request port
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

module clint_timer (
	input wire logic clock,
	input wire logic reset_i,
	input wire logic [`ADDR_LEN-1:0] req_addr_i,
	input wire logic req_valid_i,
	output logic req_ready_o,
	output logic [`DATA_LEN-1:0] rsp_data_o,
	output axi_pkg::axi_resp_t rsp_resp_o,
	output logic rsp_valid_o,
	input wire logic rsp_ready_i
);
	import axi_pkg::*;

	logic [63:0] mtime;
	logic [`ADDR_LEN-1:0] req_off;

	assign req_off = req_addr_i - `CLINT_BASE;
	assign req_ready_o = !rsp_valid_o;	// one reply in flight
	assign rsp_resp_o = RESP_OKAY;

	always_ff @(posedge clock) begin
		if (reset_i)
			mtime <= '0;
		else
			mtime <= mtime + 64'd1;
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			rsp_valid_o <= 1'b0;
		end else if (req_valid_i && req_ready_o) begin
			rsp_valid_o <= 1'b1;
			case (req_off)
				`CLINT_MTIME_LO: rsp_data_o <= mtime[31:0];
				`CLINT_MTIME_HI: rsp_data_o <= mtime[63:32];
				default: rsp_data_o <= '0;	// no other registers
			endcase
		end else if (rsp_valid_o && rsp_ready_i) begin
			rsp_valid_o <= 1'b0;
		end
	end

	// an accepted request blocks the port until its reply
	assert property (@(posedge clock) disable iff (reset_i)
		req_valid_i && req_ready_o |=> rsp_valid_o && !req_ready_o);

	// a stalled reply keeps its value
	assert property (@(posedge clock) disable iff (reset_i)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o));

endmodule

`default_nettype wire

//--- verilog/axi_sram.sv
//--------------------------------------------------
// AXI slave word memory, INCR bursts with strobes
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

module axi_sram (
	input wire logic clock,
	input wire logic reset_i,

	input wire logic [`ADDR_LEN-1:0] axi_addr_r_addr_i,
	input wire logic axi_addr_r_valid_i,
	output logic axi_addr_r_ready_o,
	input wire axi_pkg::axi_id_t axi_addr_r_id_i,
	input wire axi_pkg::axi_len_t axi_addr_r_len_i,
	input wire axi_pkg::axi_size_t axi_addr_r_size_i,
	input wire axi_pkg::axi_burst_t axi_addr_r_burst_i,

	output logic [`DATA_LEN-1:0] axi_r_data_o,
	output axi_pkg::axi_resp_t axi_r_resp_o,
	output logic axi_r_valid_o,
	input wire logic axi_r_ready_i,
	output logic axi_r_last_o,
	output axi_pkg::axi_id_t axi_r_id_o,

	input wire logic [`ADDR_LEN-1:0] axi_addr_w_addr_i,
	input wire logic axi_addr_w_valid_i,
	output logic axi_addr_w_ready_o,
	input wire axi_pkg::axi_id_t axi_addr_w_id_i,
	input wire axi_pkg::axi_len_t axi_addr_w_len_i,
	input wire axi_pkg::axi_size_t axi_addr_w_size_i,
	input wire axi_pkg::axi_burst_t axi_addr_w_burst_i,

	input wire logic [`DATA_LEN-1:0] axi_w_data_i,
	input wire logic [`DATA_LEN/8-1:0] axi_w_strb_i,
	input wire logic axi_w_valid_i,
	output logic axi_w_ready_o,
	input wire logic axi_w_last_i,

	output axi_pkg::axi_resp_t axi_bkwd_resp_o,
	output logic axi_bkwd_valid_o,
	input wire logic axi_bkwd_ready_i,
	output axi_pkg::axi_id_t axi_bkwd_id_o
);
	import axi_pkg::*;

	localparam int IDX_W = `ADDR_LEN - 2;
	localparam int MEM_AW = $clog2(`SRAM_WORDS);
	localparam int STRB_W = `DATA_LEN / 8;

	logic [`DATA_LEN-1:0] mem [`SRAM_WORDS];

	logic [`ADDR_LEN-1:0] ar_off;
	logic [`ADDR_LEN-1:0] aw_off;
	logic ar_hs, r_hs, aw_hs, w_hs, b_hs;

	logic rd_busy;
	logic rd_bad;	// burst type or size not served
	logic rd_err;
	logic [IDX_W-1:0] rd_idx;
	axi_len_t rd_cnt;	// beats left after this one

	logic wr_busy;
	logic wr_bad;
	logic wr_err;	// sticky over the burst
	logic w_err;
	logic [IDX_W-1:0] wr_idx;

	assign ar_off = axi_addr_r_addr_i - `SRAM_BASE;
	assign ar_hs = axi_addr_r_valid_i && axi_addr_r_ready_o;
	assign r_hs = axi_r_valid_o && axi_r_ready_i;

	assign axi_addr_r_ready_o = !rd_busy;
	assign axi_r_valid_o = rd_busy;
	assign axi_r_last_o = (rd_cnt == '0);
	assign rd_err = rd_bad || (rd_idx >= IDX_W'(`SRAM_WORDS));
	assign axi_r_resp_o = rd_err ? RESP_SLVERR : RESP_OKAY;
	assign axi_r_data_o = rd_err ? '0 : mem[rd_idx[MEM_AW-1:0]];

	always_ff @(posedge clock) begin
		if (reset_i) begin
			rd_busy <= 1'b0;
		end else if (ar_hs) begin
			rd_busy <= 1'b1;
			rd_idx <= ar_off[`ADDR_LEN-1:2];	// word index from base
			rd_cnt <= axi_addr_r_len_i;
			axi_r_id_o <= axi_addr_r_id_i;
			rd_bad <= (axi_addr_r_burst_i != BURST_INCR) || (axi_addr_r_size_i != SIZE_4B);
		end else if (r_hs) begin
			rd_busy <= !axi_r_last_o;
			rd_idx <= rd_idx + 1'b1;	// held while stalled
			rd_cnt <= rd_cnt - 1'b1;
		end
	end

	assign aw_off = axi_addr_w_addr_i - `SRAM_BASE;
	assign aw_hs = axi_addr_w_valid_i && axi_addr_w_ready_o;
	assign w_hs = axi_w_valid_i && axi_w_ready_o;
	assign b_hs = axi_bkwd_valid_o && axi_bkwd_ready_i;

	assign axi_addr_w_ready_o = !wr_busy && !axi_bkwd_valid_o;
	assign axi_w_ready_o = wr_busy;
	assign w_err = wr_bad || (wr_idx >= IDX_W'(`SRAM_WORDS));

	always_ff @(posedge clock) begin
		if (reset_i) begin
			wr_busy <= 1'b0;
			axi_bkwd_valid_o <= 1'b0;
		end else begin
			if (aw_hs) begin
				wr_busy <= 1'b1;
				wr_idx <= aw_off[`ADDR_LEN-1:2];
				wr_err <= 1'b0;
				wr_bad <= (axi_addr_w_burst_i != BURST_INCR) || (axi_addr_w_size_i != SIZE_4B);
				axi_bkwd_id_o <= axi_addr_w_id_i;
			end
			if (w_hs) begin
				wr_idx <= wr_idx + 1'b1;
				wr_err <= wr_err || w_err;
				if (axi_w_last_i) begin
					wr_busy <= 1'b0;
					axi_bkwd_valid_o <= 1'b1;	// B one cycle after last W
					axi_bkwd_resp_o <= (wr_err || w_err) ? RESP_SLVERR : RESP_OKAY;
				end
			end
			if (b_hs)
				axi_bkwd_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (w_hs && !w_err) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (axi_w_strb_i[b])
					mem[wr_idx[MEM_AW-1:0]][b*8 +: 8] <= axi_w_data_i[b*8 +: 8];
			end
		end
	end

	// only the final counted beat closes the burst
	assert property (@(posedge clock) disable iff (reset_i)
		r_hs |=> axi_r_valid_o == !$past(axi_r_last_o));

endmodule

`default_nettype wire

//--- verilog/soc_map_pkg.sv
//--------------------------------------------------
// crossbar targets and address map regions
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

package soc_map_pkg;

	typedef enum logic [1:0] {
		DEV_SRAM = 2'd0,
		DEV_CLINT = 2'd1,
		DEV_NONE = 2'd2
	} xbar_dev_t;

	localparam logic [`ADDR_LEN-1:0] SRAM_REGION_LO = `SRAM_BASE;
	localparam logic [`ADDR_LEN-1:0] SRAM_REGION_HI = `SRAM_BASE + `SRAM_WORDS * 4 - 1;
	localparam logic [`ADDR_LEN-1:0] CLINT_REGION_LO = `CLINT_BASE;
	localparam logic [`ADDR_LEN-1:0] CLINT_REGION_HI = `CLINT_BASE + `CLINT_SPAN - 1;

	function automatic xbar_dev_t addr_to_dev(input logic [`ADDR_LEN-1:0] addr);
		if (addr >= SRAM_REGION_LO && addr <= SRAM_REGION_HI)
			return DEV_SRAM;
		if (addr >= CLINT_REGION_LO && addr <= CLINT_REGION_HI)
			return DEV_CLINT;
		return DEV_NONE;	// unmapped hole
	endfunction

endpackage

`default_nettype wire

//--- verilog/axi_pkg.sv
//--------------------------------------------------
// AXI protocol field types and codes
//--------------------------------------------------
`default_nettype none
`include "axi_xbar_cfg.svh"

package axi_pkg;

	typedef logic [1:0] axi_resp_t;
	localparam axi_resp_t RESP_OKAY = 2'd0;
	localparam axi_resp_t RESP_SLVERR = 2'd2;	// device refused the access
	localparam axi_resp_t RESP_DECERR = 2'd3;	// no device at this address

	typedef logic [1:0] axi_burst_t;
	localparam axi_burst_t BURST_INCR = 2'd1;	// the only burst served

	typedef logic [2:0] axi_size_t;
	localparam axi_size_t SIZE_4B = 3'd2;	// full 32-bit beats

	typedef logic [`ID_LEN-1:0] axi_id_t;
	typedef logic [7:0] axi_len_t;	// beats minus one

endpackage

`default_nettype wire

//--- include/axi_xbar_cfg.svh
//--------------------------------------------------
// bus widths and address map of the AXI subsystem
//--------------------------------------------------
`ifndef AXI_XBAR_CFG_SVH
`define AXI_XBAR_CFG_SVH

`define ADDR_LEN 32
`define DATA_LEN 32
`define ID_LEN 4

// SRAM window, one word per 4 bytes
`define SRAM_BASE 32'h8000_0000
`define SRAM_WORDS 256

// CLINT window and its mtime registers
`define CLINT_BASE 32'h0200_0000
`define CLINT_SPAN 32'h0001_0000
`define CLINT_MTIME_LO 32'h0000_BFF8
`define CLINT_MTIME_HI 32'h0000_BFFC

`endif
